// File: Makefile
# Verilator build and run of the dispatch stage testbench

VERILATOR ?= verilator
TOP       ?= dispatch_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := All checks passed

SOURCES := $(wildcard src/*.sv src/*.svh test/*.sv test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: src/dispatch_cfg.svh
// ==========================================================
// Dispatch stage configuration
// Widths, counts and funct3 codes used across the stage
// ==========================================================
`ifndef DISPATCH_CFG_SVH
`define DISPATCH_CFG_SVH

// Issue width and VRF read ports
`define NUM_DP_UOP          2
`define NUM_DP_VRF          4

// ROB geometry
`define ROB_DEPTH           8
`define ROB_DEPTH_WIDTH     3

// Register and data widths
`define REGFILE_INDEX_WIDTH 5
`define VLEN                128
`define XLEN                32

// funct3 categories that carry a scalar or immediate operand
`define FUNCT3_OPIVI        3'b011
`define FUNCT3_OPIVX        3'b100
`define FUNCT3_OPMVX        3'b110

`endif

// File: src/dispatch_issue.sv
// ==========================================================
// Dispatch issue control
// Operand select, hazard checks, handshakes, RS/ROB payloads
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_cfg.svh"

module dispatch_issue import dispatch_pkg::*; (
    input  logic      [`NUM_DP_UOP-1:0]      uop_valid,
    input  uop_t      [`NUM_DP_UOP-1:0]      uop,
    input  uop_hits_t [`NUM_DP_UOP-1:0]      uop_hits,
    input  uop_opn_t  [`NUM_DP_UOP-1:0]      vrf_opn,
    input  logic                             port_conflict,
    input  logic      [`NUM_DP_UOP-1:0]      alu_ready,
    input  logic      [`NUM_DP_UOP-1:0]      mul_ready,
    input  logic      [`NUM_DP_UOP-1:0]      rob_ready,
    input  logic      [`ROB_DEPTH_WIDTH-1:0] rob_tail_index,
    output logic      [`NUM_DP_UOP-1:0]      uop_ready,
    output logic      [`NUM_DP_UOP-1:0]      alu_valid,
    output alu_rs_t   [`NUM_DP_UOP-1:0]      alu_rs,
    output logic      [`NUM_DP_UOP-1:0]      mul_valid,
    output mul_rs_t   [`NUM_DP_UOP-1:0]      mul_rs,
    output logic      [`NUM_DP_UOP-1:0]      rob_valid,
    output rob_push_t [`NUM_DP_UOP-1:0]      rob_push
);

    localparam logic [`ROB_DEPTH_WIDTH:0] DEPTH = `ROB_DEPTH;

    uop_opn_t [`NUM_DP_UOP-1:0]                       opn;
    logic     [`NUM_DP_UOP-1:0]                       rob_stall;
    logic     [`NUM_DP_UOP-1:0]                       slot_ok;
    logic     [`NUM_DP_UOP-1:0]                       issue;
    logic     [`NUM_DP_UOP-1:0][`ROB_DEPTH_WIDTH-1:0] rob_idx;
    logic                                             raw_01;

    // Forward a ready ROB result, else fall back to the VRF read
    function automatic logic [`VLEN-1:0] pick(input src_hit_t h, input logic [`VLEN-1:0] vrf);
        return (h.hit && h.ready) ? h.data : vrf;
    endfunction

    function automatic logic reads_reg(
        input uop_t                            u,
        input logic [`REGFILE_INDEX_WIDTH-1:0] idx
    );
        return (u.vs1_valid && (u.vs1_index == idx)) ||
               (u.vs2_valid && (u.vs2_index == idx)) ||
               (u.vs3_valid && (u.vd_index == idx))  ||
               (!u.vm && (idx == '0));
    endfunction

    // uop1 depends on the result uop0 is about to produce
    assign raw_01 = uop[0].vd_valid && reads_reg(uop[1], uop[0].vd_index);

    for (genvar i = 0; i < `NUM_DP_UOP; i++) begin : gen_slot
        localparam logic [`ROB_DEPTH_WIDTH:0] SLOT = i;

        logic [`ROB_DEPTH_WIDTH:0] idx_sum;
        logic [`ROB_DEPTH_WIDTH:0] idx_wrap;

        assign opn[i].vs1 = pick(uop_hits[i].vs1, vrf_opn[i].vs1);
        assign opn[i].vs2 = pick(uop_hits[i].vs2, vrf_opn[i].vs2);
        assign opn[i].vd  = pick(uop_hits[i].vd, vrf_opn[i].vd);
        assign opn[i].v0  = pick(uop_hits[i].v0, vrf_opn[i].v0);

        // Writer still in flight with no result yet
        assign rob_stall[i] = (uop_hits[i].vs1.hit && !uop_hits[i].vs1.ready) ||
                              (uop_hits[i].vs2.hit && !uop_hits[i].vs2.ready) ||
                              (uop_hits[i].vd.hit  && !uop_hits[i].vd.ready)  ||
                              (uop_hits[i].v0.hit  && !uop_hits[i].v0.ready);

        assign slot_ok[i] = !rob_stall[i] && rob_ready[i] &&
                            ((uop[i].exe_unit == EXE_MUL) ? mul_ready[i] : alu_ready[i]);

        // ROB slot follows the tail and wraps at the ROB depth
        assign idx_sum    = {1'b0, rob_tail_index} + SLOT;
        assign idx_wrap   = (idx_sum >= DEPTH) ? (idx_sum - DEPTH) : idx_sum;
        assign rob_idx[i] = idx_wrap[`ROB_DEPTH_WIDTH-1:0];

        assign uop_ready[i] = issue[i];
        assign rob_valid[i] = issue[i];
        assign alu_valid[i] = issue[i] && (uop[i].exe_unit == EXE_ALU);
        assign mul_valid[i] = issue[i] && (uop[i].exe_unit == EXE_MUL);

        assign alu_rs[i].rob_index = rob_idx[i];
        assign alu_rs[i].funct6    = uop[i].funct6;
        assign alu_rs[i].funct3    = uop[i].funct3;
        assign alu_rs[i].vm        = uop[i].vm;
        assign alu_rs[i].vs1_index = uop[i].vs1_index;
        assign alu_rs[i].vs1_data  = opn[i].vs1;
        assign alu_rs[i].vs1_valid = uop[i].vs1_valid;
        assign alu_rs[i].vs2_data  = opn[i].vs2;
        assign alu_rs[i].vs2_valid = uop[i].vs2_valid;
        assign alu_rs[i].vd_data   = opn[i].vd;
        assign alu_rs[i].vd_valid  = uop[i].vs3_valid;
        assign alu_rs[i].v0_data   = opn[i].v0;
        assign alu_rs[i].v0_valid  = !uop[i].vm;
        assign alu_rs[i].rs1_data  = uop[i].rs1_data;
        // Scalar and immediate forms carry their operand in rs1_data
        assign alu_rs[i].rs1_valid = (uop[i].funct3 == `FUNCT3_OPIVX) ||
                                     (uop[i].funct3 == `FUNCT3_OPIVI) ||
                                     (uop[i].funct3 == `FUNCT3_OPMVX);

        assign mul_rs[i].rob_index = rob_idx[i];
        assign mul_rs[i].funct6    = uop[i].funct6;
        assign mul_rs[i].funct3    = uop[i].funct3;
        assign mul_rs[i].vs1_data  = opn[i].vs1;
        assign mul_rs[i].vs1_valid = uop[i].vs1_valid;
        assign mul_rs[i].vs2_data  = opn[i].vs2;
        assign mul_rs[i].vs2_valid = uop[i].vs2_valid;
        assign mul_rs[i].vs3_data  = opn[i].vd;
        assign mul_rs[i].vs3_valid = uop[i].vs3_valid;
        assign mul_rs[i].rs1_data  = uop[i].rs1_data;

        assign rob_push[i].vd_index = uop[i].vd_index;
        assign rob_push[i].vd_valid = uop[i].vd_valid;
        assign rob_push[i].uop_pc   = uop[i].uop_pc;
    end

    // In-order issue, uop1 only goes out together with uop0
    assign issue[0] = uop_valid[0] && slot_ok[0];
    assign issue[1] = uop_valid[1] && slot_ok[1] && issue[0] && !raw_01 && !port_conflict;

endmodule

`default_nettype wire

// File: src/dispatch_pkg.sv
// ==========================================================
// Dispatch stage types
// Queue entries, ROB views, operands and RS/ROB payloads
// ==========================================================
`default_nettype none

`include "dispatch_cfg.svh"

package dispatch_pkg;

    typedef enum logic {
        EXE_ALU = 1'b0,
        EXE_MUL = 1'b1
    } exe_unit_e;

    // One entry of the uop queue
    typedef struct packed {
        exe_unit_e                        exe_unit;
        logic [5:0]                       funct6;
        logic [2:0]                       funct3;
        logic [`REGFILE_INDEX_WIDTH-1:0]  vs1_index;
        logic                             vs1_valid;
        logic [`REGFILE_INDEX_WIDTH-1:0]  vs2_index;
        logic                             vs2_valid;
        logic [`REGFILE_INDEX_WIDTH-1:0]  vd_index;
        logic                             vd_valid;
        logic                             vs3_valid;
        logic                             vm;
        logic [`XLEN-1:0]                 rs1_data;
        logic [`XLEN-1:0]                 uop_pc;
    } uop_t;

    // ROB entry as seen by dispatch, w_valid means result is written
    typedef struct packed {
        logic                             valid;
        logic [`REGFILE_INDEX_WIDTH-1:0]  w_index;
        logic                             w_valid;
        logic [`VLEN-1:0]                 w_data;
    } rob_entry_t;

    // Result of one source lookup in the ROB
    typedef struct packed {
        logic                             hit;
        logic                             ready;
        logic [`VLEN-1:0]                 data;
    } src_hit_t;

    typedef struct packed {
        src_hit_t                         vs1;
        src_hit_t                         vs2;
        src_hit_t                         vd;
        src_hit_t                         v0;
    } uop_hits_t;

    typedef struct packed {
        logic [`VLEN-1:0]                 vs1;
        logic [`VLEN-1:0]                 vs2;
        logic [`VLEN-1:0]                 vd;
        logic [`VLEN-1:0]                 v0;
    } uop_opn_t;

    typedef struct packed {
        logic [`ROB_DEPTH_WIDTH-1:0]      rob_index;
        logic [5:0]                       funct6;
        logic [2:0]                       funct3;
        logic                             vm;
        logic [`REGFILE_INDEX_WIDTH-1:0]  vs1_index;
        logic [`VLEN-1:0]                 vs1_data;
        logic                             vs1_valid;
        logic [`VLEN-1:0]                 vs2_data;
        logic                             vs2_valid;
        logic [`VLEN-1:0]                 vd_data;
        logic                             vd_valid;
        logic [`VLEN-1:0]                 v0_data;
        logic                             v0_valid;
        logic [`XLEN-1:0]                 rs1_data;
        logic                             rs1_valid;
    } alu_rs_t;

    typedef struct packed {
        logic [`ROB_DEPTH_WIDTH-1:0]      rob_index;
        logic [5:0]                       funct6;
        logic [2:0]                       funct3;
        logic [`VLEN-1:0]                 vs1_data;
        logic                             vs1_valid;
        logic [`VLEN-1:0]                 vs2_data;
        logic                             vs2_valid;
        logic [`VLEN-1:0]                 vs3_data;
        logic                             vs3_valid;
        logic [`XLEN-1:0]                 rs1_data;
    } mul_rs_t;

    typedef struct packed {
        logic [`REGFILE_INDEX_WIDTH-1:0]  vd_index;
        logic                             vd_valid;
        logic [`XLEN-1:0]                 uop_pc;
    } rob_push_t;

endpackage

`default_nettype wire

// File: src/dispatch_rob_lookup.sv
// ==========================================================
// Dispatch ROB lookup
// Finds the youngest in-flight writer of every source
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_cfg.svh"

module dispatch_rob_lookup import dispatch_pkg::*; (
    input  uop_t       [`NUM_DP_UOP-1:0] uop,
    input  rob_entry_t [`ROB_DEPTH-1:0]  rob_entries,
    output uop_hits_t  [`NUM_DP_UOP-1:0] uop_hits
);

    // Scan oldest to youngest so the last match found is the youngest one
    function automatic src_hit_t find_src(
        input logic                             rd,
        input logic [`REGFILE_INDEX_WIDTH-1:0]  idx,
        input rob_entry_t [`ROB_DEPTH-1:0]      ents
    );
        src_hit_t res;
        res = '0;
        for (int j = 0; j < `ROB_DEPTH; j++) begin
            if (rd && ents[j].valid && (ents[j].w_index == idx)) begin
                res.hit   = 1'b1;
                res.ready = ents[j].w_valid;
                res.data  = ents[j].w_data;
            end
        end
        return res;
    endfunction

    for (genvar i = 0; i < `NUM_DP_UOP; i++) begin : gen_uop
        // Sources not read by the uop never report a hit
        assign uop_hits[i].vs1 = find_src(uop[i].vs1_valid, uop[i].vs1_index, rob_entries);
        assign uop_hits[i].vs2 = find_src(uop[i].vs2_valid, uop[i].vs2_index, rob_entries);
        assign uop_hits[i].vd  = find_src(uop[i].vs3_valid, uop[i].vd_index, rob_entries);

        // Masked uops read v0 as the mask register
        assign uop_hits[i].v0  = find_src(!uop[i].vm, '0, rob_entries);
    end

endmodule

`default_nettype wire

// File: src/dispatch_vrf_read.sv
// ==========================================================
// Dispatch VRF read
// Maps sources onto the four read ports, flags port clashes
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_cfg.svh"

module dispatch_vrf_read import dispatch_pkg::*; (
    input  uop_t     [`NUM_DP_UOP-1:0]                           uop,
    output logic     [`NUM_DP_VRF-1:0][`REGFILE_INDEX_WIDTH-1:0] vrf_rd_index,
    input  logic     [`NUM_DP_VRF-1:0][`VLEN-1:0]                vrf_rd_data,
    input  logic     [`VLEN-1:0]                                 v0_data,
    output uop_opn_t [`NUM_DP_UOP-1:0]                           vrf_opn,
    output logic                                                 port_conflict
);

    logic port1_to_uop0;
    logic port3_to_uop0;

    // Ports 1 and 3 are shared between vs1 of one uop and vd of the other
    assign port1_to_uop0 = uop[0].vs1_valid;
    assign port3_to_uop0 = uop[0].vs3_valid || !uop[1].vs1_valid;

    assign vrf_rd_index[0] = uop[0].vs2_index;
    assign vrf_rd_index[1] = port1_to_uop0 ? uop[0].vs1_index : uop[1].vd_index;
    assign vrf_rd_index[2] = uop[1].vs2_index;
    assign vrf_rd_index[3] = port3_to_uop0 ? uop[0].vd_index : uop[1].vs1_index;

    // Both uops want the same shared port, uop0 keeps it
    assign port_conflict = (uop[0].vs1_valid && uop[1].vs3_valid) ||
                           (uop[1].vs1_valid && uop[0].vs3_valid);

    // Slot i reads vs2 on port 2i, vs1 on port 2i+1 and vd on the other uop's odd port
    for (genvar i = 0; i < `NUM_DP_UOP; i++) begin : gen_route
        assign vrf_opn[i].vs2 = vrf_rd_data[2*i];
        assign vrf_opn[i].vs1 = vrf_rd_data[2*i+1];
        assign vrf_opn[i].vd  = vrf_rd_data[(2*i+3) % `NUM_DP_VRF];
        assign vrf_opn[i].v0  = v0_data;
    end

endmodule

`default_nettype wire

// File: src/rvv_dispatch.sv
// ==========================================================
// Two-wide vector dispatch stage
// Uop queue to ALU/MUL reservation stations and the ROB
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_cfg.svh"

module rvv_dispatch import dispatch_pkg::*; (
    // Uop queue
    input  logic       [`NUM_DP_UOP-1:0]                           uop_valid,
    input  uop_t       [`NUM_DP_UOP-1:0]                           uop,
    output logic       [`NUM_DP_UOP-1:0]                           uop_ready,
    // ALU reservation station
    output logic       [`NUM_DP_UOP-1:0]                           alu_valid,
    output alu_rs_t    [`NUM_DP_UOP-1:0]                           alu_rs,
    input  logic       [`NUM_DP_UOP-1:0]                           alu_ready,
    // MUL reservation station
    output logic       [`NUM_DP_UOP-1:0]                           mul_valid,
    output mul_rs_t    [`NUM_DP_UOP-1:0]                           mul_rs,
    input  logic       [`NUM_DP_UOP-1:0]                           mul_ready,
    // ROB push
    output logic       [`NUM_DP_UOP-1:0]                           rob_valid,
    output rob_push_t  [`NUM_DP_UOP-1:0]                           rob_push,
    input  logic       [`NUM_DP_UOP-1:0]                           rob_ready,
    input  logic       [`ROB_DEPTH_WIDTH-1:0]                      rob_tail_index,
    // VRF read, data comes back in the same cycle
    output logic       [`NUM_DP_VRF-1:0][`REGFILE_INDEX_WIDTH-1:0] vrf_rd_index,
    input  logic       [`NUM_DP_VRF-1:0][`VLEN-1:0]                vrf_rd_data,
    input  logic       [`VLEN-1:0]                                 v0_data,
    // Whole ROB, oldest entry at index 0
    input  rob_entry_t [`ROB_DEPTH-1:0]                            rob_entries
);

    uop_hits_t [`NUM_DP_UOP-1:0] uop_hits;
    uop_opn_t  [`NUM_DP_UOP-1:0] vrf_opn;
    logic                        port_conflict;

    dispatch_rob_lookup dispatch_rob_lookup_inst (
        .uop            (uop),
        .rob_entries    (rob_entries),
        .uop_hits       (uop_hits)
    );

    dispatch_vrf_read dispatch_vrf_read_inst (
        .uop            (uop),
        .vrf_rd_index   (vrf_rd_index),
        .vrf_rd_data    (vrf_rd_data),
        .v0_data        (v0_data),
        .vrf_opn        (vrf_opn),
        .port_conflict  (port_conflict)
    );

    dispatch_issue dispatch_issue_inst (
        .uop_valid      (uop_valid),
        .uop            (uop),
        .uop_hits       (uop_hits),
        .vrf_opn        (vrf_opn),
        .port_conflict  (port_conflict),
        .alu_ready      (alu_ready),
        .mul_ready      (mul_ready),
        .rob_ready      (rob_ready),
        .rob_tail_index (rob_tail_index),
        .uop_ready      (uop_ready),
        .alu_valid      (alu_valid),
        .alu_rs         (alu_rs),
        .mul_valid      (mul_valid),
        .mul_rs         (mul_rs),
        .rob_valid      (rob_valid),
        .rob_push       (rob_push)
    );

endmodule

`default_nettype wire

// File: test/dispatch_model.svh
// ==========================================================
// Dispatch reference model
// Expected port map, operands, hazards and issue per cycle
// ==========================================================
`ifndef DISPATCH_MODEL_SVH
`define DISPATCH_MODEL_SVH

logic      [`NUM_DP_UOP-1:0]                           exp_issue;
logic      [`NUM_DP_UOP-1:0]                           exp_is_mul;
logic      [`NUM_DP_VRF-1:0][`REGFILE_INDEX_WIDTH-1:0] exp_rd_index;
alu_rs_t   [`NUM_DP_UOP-1:0]                           exp_alu;
mul_rs_t   [`NUM_DP_UOP-1:0]                           exp_mul;
rob_push_t [`NUM_DP_UOP-1:0]                           exp_push;

// Register contents returned by the VRF responder
function automatic logic [`VLEN-1:0] vrf_value(input logic [`REGFILE_INDEX_WIDTH-1:0] idx);
    return {16{3'b101, idx}};
endfunction

// Search from the youngest entry down so the first valid match wins
function automatic src_hit_t youngest_writer(input logic [`REGFILE_INDEX_WIDTH-1:0] idx);
    src_hit_t res;
    res = '0;
    for (int j = `ROB_DEPTH - 1; j >= 0; j--) begin
        if (!res.hit && rob_entries[j].valid && rob_entries[j].w_index == idx) begin
            res.hit   = 1'b1;
            res.ready = rob_entries[j].w_valid;
            res.data  = rob_entries[j].w_data;
        end
    end
    return res;
endfunction

task automatic predict_outputs();
    uop_t                                 u;
    src_hit_t                             h;
    logic [3:0]                           rd;
    logic [3:0][`REGFILE_INDEX_WIDTH-1:0] idx;
    logic [3:0][`VLEN-1:0]                dat;
    logic [`NUM_DP_UOP-1:0]               ok;
    logic                                 stall;
    logic                                 raw;
    logic                                 conflict;
    logic                                 rs1_valid;
    int                                   tail;

    // uop0 keeps the shared ports 1 and 3 in the fixed port map
    exp_rd_index[0] = uop[0].vs2_index;
    exp_rd_index[1] = uop[0].vs1_valid ? uop[0].vs1_index : uop[1].vd_index;
    exp_rd_index[2] = uop[1].vs2_index;
    exp_rd_index[3] = (uop[1].vs1_valid && !uop[0].vs3_valid) ?
                      uop[1].vs1_index : uop[0].vd_index;

    raw = 1'b0;
    for (int i = 0; i < `NUM_DP_UOP; i++) begin
        u = uop[i];
        // Source order is vs1, vs2, vd, v0
        rd    = {!u.vm, u.vs3_valid, u.vs2_valid, u.vs1_valid};
        idx   = {{`REGFILE_INDEX_WIDTH{1'b0}}, u.vd_index, u.vs2_index, u.vs1_index};
        // Every source starts from the data of its mapped VRF port
        dat[0] = vrf_value(exp_rd_index[(i == 0) ? 1 : 3]);
        dat[1] = vrf_value(exp_rd_index[(i == 0) ? 0 : 2]);
        dat[2] = vrf_value(exp_rd_index[(i == 0) ? 3 : 1]);
        dat[3] = v0_data;
        stall = 1'b0;
        for (int k = 0; k < 4; k++) begin
            h = youngest_writer(idx[k]);
            if (rd[k] && h.hit && h.ready) dat[k] = h.data;
            if (rd[k] && h.hit && !h.ready) stall = 1'b1;
            // uop1 reads what uop0 is about to write
            if (i == 1 && rd[k] && uop[0].vd_valid && idx[k] == uop[0].vd_index) raw = 1'b1;
        end
        exp_is_mul[i] = (u.exe_unit == EXE_MUL);
        ok[i] = uop_valid[i] && !stall && rob_ready[i] &&
                (exp_is_mul[i] ? mul_ready[i] : alu_ready[i]);

        tail      = (int'(rob_tail_index) + i) % `ROB_DEPTH;
        rs1_valid = u.funct3 inside {`FUNCT3_OPIVI, `FUNCT3_OPIVX, `FUNCT3_OPMVX};
        exp_alu[i] = {tail[`ROB_DEPTH_WIDTH-1:0], u.funct6, u.funct3, u.vm, u.vs1_index,
                      dat[0], u.vs1_valid, dat[1], u.vs2_valid, dat[2], u.vs3_valid,
                      dat[3], !u.vm, u.rs1_data, rs1_valid};
        exp_mul[i] = {tail[`ROB_DEPTH_WIDTH-1:0], u.funct6, u.funct3, dat[0], u.vs1_valid,
                      dat[1], u.vs2_valid, dat[2], u.vs3_valid, u.rs1_data};
        exp_push[i] = {u.vd_index, u.vd_valid, u.uop_pc};
    end

    // A shared port wanted by both uops blocks uop1
    conflict = (uop[0].vs1_valid && uop[1].vs3_valid) ||
               (uop[1].vs1_valid && uop[0].vs3_valid);
    exp_issue[0] = ok[0];
    exp_issue[1] = ok[1] && ok[0] && !raw && !conflict;
endtask

`endif

// File: test/dispatch_tb.sv
// ==========================================================
// Dispatch stage testbench
// Random uops and ROB state checked against a reference model
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_cfg.svh"

module dispatch_tb import dispatch_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 4;
    localparam int RUN_CYCLES   = 3000;
    localparam int WIDE         = 576;

    logic                                             clk = 1'b0;
    logic                                             arst_n;
    logic       [`NUM_DP_UOP-1:0]                     uop_valid;
    uop_t       [`NUM_DP_UOP-1:0]                     uop;
    logic       [`NUM_DP_UOP-1:0]                     uop_ready;
    logic       [`NUM_DP_UOP-1:0]                     alu_valid;
    alu_rs_t    [`NUM_DP_UOP-1:0]                     alu_rs;
    logic       [`NUM_DP_UOP-1:0]                     alu_ready;
    logic       [`NUM_DP_UOP-1:0]                     mul_valid;
    mul_rs_t    [`NUM_DP_UOP-1:0]                     mul_rs;
    logic       [`NUM_DP_UOP-1:0]                     mul_ready;
    logic       [`NUM_DP_UOP-1:0]                     rob_valid;
    rob_push_t  [`NUM_DP_UOP-1:0]                     rob_push;
    logic       [`NUM_DP_UOP-1:0]                     rob_ready;
    logic       [`ROB_DEPTH_WIDTH-1:0]                rob_tail_index;
    logic       [`NUM_DP_VRF-1:0][`REGFILE_INDEX_WIDTH-1:0] vrf_rd_index;
    logic       [`NUM_DP_VRF-1:0][`VLEN-1:0]          vrf_rd_data;
    logic       [`VLEN-1:0]                           v0_data;
    rob_entry_t [`ROB_DEPTH-1:0]                      rob_entries;

    integer seed        = 32'hd8f;
    int     error_count = 0;
    int     check_count = 0;

    `include "dispatch_model.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    // VRF answers in the same cycle
    always_comb begin
        for (int p = 0; p < `NUM_DP_VRF; p++) begin
            vrf_rd_data[p] = vrf_value(vrf_rd_index[p]);
        end
    end

    rvv_dispatch rvv_dispatch_inst (
        .uop_valid      (uop_valid),
        .uop            (uop),
        .uop_ready      (uop_ready),
        .alu_valid      (alu_valid),
        .alu_rs         (alu_rs),
        .alu_ready      (alu_ready),
        .mul_valid      (mul_valid),
        .mul_rs         (mul_rs),
        .mul_ready      (mul_ready),
        .rob_valid      (rob_valid),
        .rob_push       (rob_push),
        .rob_ready      (rob_ready),
        .rob_tail_index (rob_tail_index),
        .vrf_rd_index   (vrf_rd_index),
        .vrf_rd_data    (vrf_rd_data),
        .v0_data        (v0_data),
        .rob_entries    (rob_entries)
    );

    // Register indices stay in 0..7 so ROB and uop0/uop1 matches are common
    task automatic make_uop(output uop_t u);
        logic [31:0] r;
        r = $random(seed);
        u.exe_unit  = exe_unit_e'(r[0]);
        u.funct6    = r[6:1];
        u.funct3    = r[9:7];
        u.vs1_index = {2'b00, r[12:10]};
        u.vs1_valid = r[13];
        u.vs2_index = {2'b00, r[16:14]};
        u.vs2_valid = r[17];
        u.vd_index  = {2'b00, r[20:18]};
        u.vd_valid  = r[21];
        u.vs3_valid = r[22];
        u.vm        = r[23] | r[24];
        u.rs1_data  = $random(seed);
        u.uop_pc    = $random(seed);
    endtask

    task automatic drive_inputs();
        uop_t                        u0;
        uop_t                        u1;
        rob_entry_t [`ROB_DEPTH-1:0] ents;
        logic [31:0]                 r;
        make_uop(u0);
        make_uop(u1);
        for (int j = 0; j < `ROB_DEPTH; j++) begin
            r = $random(seed);
            ents[j].valid   = (r[1:0] == 2'b00);
            ents[j].w_index = {2'b00, r[4:2]};
            ents[j].w_valid = (r[6:5] != 2'b00);
            ents[j].w_data  = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        r = $random(seed);
        uop            <= {u1, u0};
        uop_valid      <= arst_n ? {r[2:0] != 3'b000, r[5:3] != 3'b000} : 2'b00;
        alu_ready      <= {r[8:6] != 3'b000, r[11:9] != 3'b000};
        mul_ready      <= {r[14:12] != 3'b000, r[17:15] != 3'b000};
        rob_ready      <= {r[20:18] != 3'b000, r[23:21] != 3'b000};
        rob_tail_index <= r[26:24];
        v0_data        <= {$random(seed), $random(seed), $random(seed), $random(seed)};
        rob_entries    <= ents;
    endtask

    task automatic check_field(input string name, input logic [WIDE-1:0] got,
                               input logic [WIDE-1:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("FAILED %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic check_outputs();
        predict_outputs();
        for (int p = 0; p < `NUM_DP_VRF; p++) begin
            check_field($sformatf("vrf_rd_index[%0d]", p), vrf_rd_index[p], exp_rd_index[p]);
        end
        check_field("uop_ready", uop_ready, exp_issue);
        check_field("rob_valid", rob_valid, exp_issue);
        check_field("alu_valid", alu_valid, exp_issue & ~exp_is_mul);
        check_field("mul_valid", mul_valid, exp_issue & exp_is_mul);
        for (int i = 0; i < `NUM_DP_UOP; i++) begin
            if (exp_issue[i] && !exp_is_mul[i]) begin
                check_field($sformatf("alu_rs[%0d]", i), alu_rs[i], exp_alu[i]);
            end
            if (exp_issue[i] && exp_is_mul[i]) begin
                check_field($sformatf("mul_rs[%0d]", i), mul_rs[i], exp_mul[i]);
            end
            if (exp_issue[i]) begin
                check_field($sformatf("rob_push[%0d]", i), rob_push[i], exp_push[i]);
            end
        end
        if (!arst_n) begin
            check_count++;
            assert ((uop_ready | alu_valid | mul_valid | rob_valid) == '0) else begin
                error_count++;
                $display("A handshake output was active while reset was held");
            end
        end
    endtask

    always @(posedge clk) begin
        drive_inputs();
    end

    // Inputs change on the rising edge so the falling edge sees settled outputs
    always @(negedge clk) begin
        check_outputs();
    end

    initial begin
        arst_n         <= 1'b0;
        uop_valid      <= '0;
        uop            <= '0;
        alu_ready      <= '0;
        mul_ready      <= '0;
        rob_ready      <= '0;
        rob_tail_index <= '0;
        v0_data        <= '0;
        rob_entries    <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        repeat (RUN_CYCLES) @(posedge clk);
        @(negedge clk);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #((RESET_CYCLES + RUN_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout, the run did not reach its end in time");
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+src
+incdir+test
src/dispatch_pkg.sv
src/dispatch_rob_lookup.sv
src/dispatch_vrf_read.sv
src/dispatch_issue.sv
src/rvv_dispatch.sv
test/dispatch_tb.sv
